//--- logic/op_pkg.sv
package op_pkg;

    // ----------------------------
    // Functional unit select
    // ----------------------------
    typedef enum logic [0:0] {
        FU_ALU = 1'b0,
        FU_LSU = 1'b1
    } fu_t;

    // ----------------------------
    // ALU functions
    // ----------------------------
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9
    } alu_fn_t;

    // Access size in bytes, log2 encoded
    typedef enum logic [1:0] {
        SIZE_B = 2'd0,
        SIZE_H = 2'd1,
        SIZE_W = 2'd2,
        SIZE_D = 2'd3
    } mem_size_t;

    // ----------------------------
    // Operation word views
    // ----------------------------
    typedef struct packed {
        alu_fn_t    alu_fn;
        logic       word_mode;
        logic [2:0] pad;
    } alu_op_t;

    typedef struct packed {
        logic       is_store;
        mem_size_t  size;
        logic       is_unsigned;
        logic [3:0] pad;
    } lsu_op_t;

    // Same 8-bit word, read by whichever unit got the issue
    typedef union packed {
        alu_op_t alu;
        lsu_op_t lsu;
    } op_word_t;

endpackage

//--- logic/wb_pkg.sv
package wb_pkg;

    // ----------------------------
    // Datapath width
    // ----------------------------
    localparam int XLEN = 64;

    // Bytes per data word, sets the byte enable width
    localparam int XLEN_BYTES = XLEN / 8;

    // ----------------------------
    // Transaction tags
    // ----------------------------
    // Default tag width, enough for 8 results in flight
    localparam int TRANS_ID_BITS_DEFAULT = 3;

endpackage

//--- logic/alu_unit.sv
`timescale 1ns/1ps

module alu_unit #(
    parameter int TRANS_ID_BITS = 3
) (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      valid_i,
    input  op_pkg::op_word_t          op_i,
    input  logic [wb_pkg::XLEN-1:0]   a_i,
    input  logic [wb_pkg::XLEN-1:0]   b_i,
    input  logic [TRANS_ID_BITS-1:0]  trans_id_i,
    input  logic                      stall_i,
    output logic                      ready_o,
    output logic                      res_valid_o,
    output logic [wb_pkg::XLEN-1:0]   res_data_o,
    output logic [TRANS_ID_BITS-1:0]  res_trans_id_o
);

    localparam int XLEN = wb_pkg::XLEN;

    logic                     word_mode;
    logic [5:0]               shamt;
    logic [XLEN-1:0]          shift_src_l;
    logic [XLEN-1:0]          shift_src_a;
    logic [XLEN-1:0]          result_raw;
    logic [XLEN-1:0]          result_d;
    logic                     accept;
    logic                     res_valid_q;
    logic [XLEN-1:0]          res_data_q;
    logic [TRANS_ID_BITS-1:0] res_trans_id_q;

    assign word_mode = op_i.alu.word_mode;
    assign ready_o   = ~stall_i;
    assign accept    = valid_i & ready_o;

    // Word mode only looks at 5 shift bits and the low half of a
    assign shamt       = word_mode ? {1'b0, b_i[4:0]} : b_i[5:0];
    assign shift_src_l = word_mode ? {{(XLEN-32){1'b0}}, a_i[31:0]} : a_i;
    assign shift_src_a = word_mode ? {{(XLEN-32){a_i[31]}}, a_i[31:0]} : a_i;

    // ----------------------------
    // Function decode
    // ----------------------------
    always_comb begin
        unique case (op_i.alu.alu_fn)
            op_pkg::ALU_ADD:  result_raw = a_i + b_i;
            op_pkg::ALU_SUB:  result_raw = a_i - b_i;
            op_pkg::ALU_AND:  result_raw = a_i & b_i;
            op_pkg::ALU_OR:   result_raw = a_i | b_i;
            op_pkg::ALU_XOR:  result_raw = a_i ^ b_i;
            op_pkg::ALU_SLL:  result_raw = a_i << shamt;
            op_pkg::ALU_SRL:  result_raw = shift_src_l >> shamt;
            op_pkg::ALU_SRA:  result_raw = $signed(shift_src_a) >>> shamt;
            op_pkg::ALU_SLT:  result_raw = {{(XLEN-1){1'b0}}, $signed(a_i) < $signed(b_i)};
            op_pkg::ALU_SLTU: result_raw = {{(XLEN-1){1'b0}}, a_i < b_i};
            default:          result_raw = '0;
        endcase
    end

    // Sign-extend the low word for the W variants
    assign result_d = word_mode ? {{(XLEN-32){result_raw[31]}}, result_raw[31:0]} : result_raw;

    // ----------------------------
    // Result register
    // ----------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            res_valid_q <= 1'b0;
        end else begin
            res_valid_q <= accept;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            res_data_q     <= result_d;
            res_trans_id_q <= trans_id_i;
        end
    end

    assign res_valid_o    = res_valid_q;
    assign res_data_o     = res_data_q;
    assign res_trans_id_o = res_trans_id_q;

endmodule

//--- logic/lsu_unit.sv
`timescale 1ns/1ps

module lsu_unit #(
    parameter int TRANS_ID_BITS = 3,
    parameter int DMEM_WORDS    = 32
) (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      valid_i,
    input  op_pkg::op_word_t          op_i,
    input  logic [wb_pkg::XLEN-1:0]   addr_i,
    input  logic [wb_pkg::XLEN-1:0]   offset_i,
    input  logic [wb_pkg::XLEN-1:0]   wdata_i,
    input  logic [TRANS_ID_BITS-1:0]  trans_id_i,
    output logic                      ready_o,
    output logic                      res_valid_o,
    output logic [wb_pkg::XLEN-1:0]   res_data_o,
    output logic [TRANS_ID_BITS-1:0]  res_trans_id_o
);

    localparam int XLEN     = wb_pkg::XLEN;
    localparam int NBYTES   = wb_pkg::XLEN_BYTES;
    localparam int OFF_BITS = $clog2(NBYTES);
    localparam int IDX_BITS = $clog2(DMEM_WORDS);

    // Stage one
    logic                     s1_valid_q;
    logic [XLEN-1:0]          s1_addr_q;
    logic [XLEN-1:0]          s1_wdata_q;
    op_pkg::lsu_op_t          s1_op_q;
    logic [TRANS_ID_BITS-1:0] s1_trans_id_q;

    // Stage two
    logic [XLEN-1:0]          mem_q [DMEM_WORDS];
    logic [IDX_BITS-1:0]      idx;
    logic [OFF_BITS-1:0]      off;
    logic [NBYTES-1:0]        be;
    logic [XLEN-1:0]          rshift;
    logic [XLEN-1:0]          wshift;
    logic [XLEN-1:0]          ld_data;
    logic                     res_valid_q;
    logic [XLEN-1:0]          res_data_q;
    logic [TRANS_ID_BITS-1:0] res_trans_id_q;

    // Fully pipelined, one op per cycle
    assign ready_o = 1'b1;

    // ----------------------------
    // Stage one: address generation
    // ----------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            s1_valid_q <= 1'b0;
        end else begin
            s1_valid_q <= valid_i & ready_o;
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i && ready_o) begin
            s1_addr_q     <= addr_i + offset_i;
            s1_wdata_q    <= wdata_i;
            s1_op_q       <= op_i.lsu;
            s1_trans_id_q <= trans_id_i;
        end
    end

    // ----------------------------
    // Stage two: scratchpad access
    // ----------------------------
    // Upper address bits are dropped, so accesses wrap
    assign idx = s1_addr_q[OFF_BITS +: IDX_BITS];
    assign off = s1_addr_q[OFF_BITS-1:0];

    // Little-endian lane placement
    assign rshift = mem_q[idx] >> {off, 3'b000};
    assign wshift = s1_wdata_q << {off, 3'b000};

    always_comb begin
        unique case (s1_op_q.size)
            op_pkg::SIZE_B: be = NBYTES'(8'h01) << off;
            op_pkg::SIZE_H: be = NBYTES'(8'h03) << off;
            op_pkg::SIZE_W: be = NBYTES'(8'h0f) << off;
            default:        be = '1;
        endcase
    end

    // Load extension by size and signedness
    always_comb begin
        unique case (s1_op_q.size)
            op_pkg::SIZE_B:
                ld_data = {{(XLEN-8){~s1_op_q.is_unsigned & rshift[7]}}, rshift[7:0]};
            op_pkg::SIZE_H:
                ld_data = {{(XLEN-16){~s1_op_q.is_unsigned & rshift[15]}}, rshift[15:0]};
            op_pkg::SIZE_W:
                ld_data = {{(XLEN-32){~s1_op_q.is_unsigned & rshift[31]}}, rshift[31:0]};
            default:
                ld_data = rshift;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (s1_valid_q && s1_op_q.is_store) begin
            for (int i = 0; i < NBYTES; i++) begin
                if (be[i]) begin
                    mem_q[idx][8*i +: 8] <= wshift[8*i +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            res_valid_q <= 1'b0;
        end else begin
            res_valid_q <= s1_valid_q;
        end
    end

    // Stores report zero
    always_ff @(posedge clk_i) begin
        if (s1_valid_q) begin
            res_data_q     <= s1_op_q.is_store ? '0 : ld_data;
            res_trans_id_q <= s1_trans_id_q;
        end
    end

    assign res_valid_o    = res_valid_q;
    assign res_data_o     = res_data_q;
    assign res_trans_id_o = res_trans_id_q;

endmodule

//--- logic/result_merge.sv
`timescale 1ns/1ps

module result_merge #(
    parameter int TRANS_ID_BITS = 3
) (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      alu_valid_i,
    input  logic [wb_pkg::XLEN-1:0]   alu_data_i,
    input  logic [TRANS_ID_BITS-1:0]  alu_trans_id_i,
    input  logic                      lsu_valid_i,
    input  logic [wb_pkg::XLEN-1:0]   lsu_data_i,
    input  logic [TRANS_ID_BITS-1:0]  lsu_trans_id_i,
    output logic                      alu_stall_o,
    output logic                      wb_valid_o,
    output logic [wb_pkg::XLEN-1:0]   wb_data_o,
    output logic [TRANS_ID_BITS-1:0]  wb_trans_id_o
);

    logic                      collide;
    logic                      hold_valid_q;
    logic                      hold_valid_d;
    logic [wb_pkg::XLEN-1:0]   hold_data_q;
    logic [TRANS_ID_BITS-1:0]  hold_trans_id_q;

    // Both units presenting in the same cycle
    assign collide = alu_valid_i & lsu_valid_i;

    // ----------------------------
    // Writeback select
    // ----------------------------
    // LSU first, then the held ALU result, then a fresh ALU result
    always_comb begin
        if (lsu_valid_i) begin
            wb_data_o     = lsu_data_i;
            wb_trans_id_o = lsu_trans_id_i;
        end else if (hold_valid_q) begin
            wb_data_o     = hold_data_q;
            wb_trans_id_o = hold_trans_id_q;
        end else begin
            wb_data_o     = alu_data_i;
            wb_trans_id_o = alu_trans_id_i;
        end
    end

    assign wb_valid_o = lsu_valid_i | hold_valid_q | alu_valid_i;

    // ----------------------------
    // ALU hold buffer
    // ----------------------------
    // Stall also covers the collision cycle, so no ALU result
    // can land while the buffer is occupied
    assign alu_stall_o = hold_valid_q | collide;

    always_comb begin
        if (collide) begin
            hold_valid_d = 1'b1;
        end else if (!lsu_valid_i) begin
            // Port free this cycle, buffer drains
            hold_valid_d = 1'b0;
        end else begin
            hold_valid_d = hold_valid_q;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            hold_valid_q <= 1'b0;
        end else begin
            hold_valid_q <= hold_valid_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (collide) begin
            hold_data_q     <= alu_data_i;
            hold_trans_id_q <= alu_trans_id_i;
        end
    end

endmodule

//--- logic/ex_stage.sv
`timescale 1ns/1ps

module ex_stage #(
    parameter int TRANS_ID_BITS = wb_pkg::TRANS_ID_BITS_DEFAULT,
    parameter int DMEM_WORDS    = 32
) (
    input  logic                      clk_i,
    input  logic                      rst_ni,

    // ALU issue
    input  logic                      alu_valid_i,
    input  op_pkg::op_word_t          alu_op_i,
    input  logic [wb_pkg::XLEN-1:0]   alu_a_i,
    input  logic [wb_pkg::XLEN-1:0]   alu_b_i,
    input  logic [TRANS_ID_BITS-1:0]  alu_trans_id_i,
    output logic                      alu_ready_o,

    // LSU issue
    input  logic                      lsu_valid_i,
    input  op_pkg::op_word_t          lsu_op_i,
    input  logic [wb_pkg::XLEN-1:0]   lsu_addr_i,
    input  logic [wb_pkg::XLEN-1:0]   lsu_offset_i,
    input  logic [wb_pkg::XLEN-1:0]   lsu_wdata_i,
    input  logic [TRANS_ID_BITS-1:0]  lsu_trans_id_i,
    output logic                      lsu_ready_o,

    // Writeback
    output logic                      wb_valid_o,
    output logic [wb_pkg::XLEN-1:0]   wb_data_o,
    output logic [TRANS_ID_BITS-1:0]  wb_trans_id_o
);

    // ----------------------------
    // Unit <-> merge
    // ----------------------------
    logic                     alu_res_valid;
    logic [wb_pkg::XLEN-1:0]  alu_res_data;
    logic [TRANS_ID_BITS-1:0] alu_res_trans_id;
    logic                     alu_stall;
    logic                     lsu_res_valid;
    logic [wb_pkg::XLEN-1:0]  lsu_res_data;
    logic [TRANS_ID_BITS-1:0] lsu_res_trans_id;

    alu_unit #(
        .TRANS_ID_BITS ( TRANS_ID_BITS )
    ) alu_unit_i (
        .clk_i          ( clk_i            ),
        .rst_ni         ( rst_ni           ),
        .valid_i        ( alu_valid_i      ),
        .op_i           ( alu_op_i         ),
        .a_i            ( alu_a_i          ),
        .b_i            ( alu_b_i          ),
        .trans_id_i     ( alu_trans_id_i   ),
        .stall_i        ( alu_stall        ),
        .ready_o        ( alu_ready_o      ),
        .res_valid_o    ( alu_res_valid    ),
        .res_data_o     ( alu_res_data     ),
        .res_trans_id_o ( alu_res_trans_id )
    );

    lsu_unit #(
        .TRANS_ID_BITS ( TRANS_ID_BITS ),
        .DMEM_WORDS    ( DMEM_WORDS    )
    ) lsu_unit_i (
        .clk_i          ( clk_i            ),
        .rst_ni         ( rst_ni           ),
        .valid_i        ( lsu_valid_i      ),
        .op_i           ( lsu_op_i         ),
        .addr_i         ( lsu_addr_i       ),
        .offset_i       ( lsu_offset_i     ),
        .wdata_i        ( lsu_wdata_i      ),
        .trans_id_i     ( lsu_trans_id_i   ),
        .ready_o        ( lsu_ready_o      ),
        .res_valid_o    ( lsu_res_valid    ),
        .res_data_o     ( lsu_res_data     ),
        .res_trans_id_o ( lsu_res_trans_id )
    );

    result_merge #(
        .TRANS_ID_BITS ( TRANS_ID_BITS )
    ) result_merge_i (
        .clk_i          ( clk_i            ),
        .rst_ni         ( rst_ni           ),
        .alu_valid_i    ( alu_res_valid    ),
        .alu_data_i     ( alu_res_data     ),
        .alu_trans_id_i ( alu_res_trans_id ),
        .lsu_valid_i    ( lsu_res_valid    ),
        .lsu_data_i     ( lsu_res_data     ),
        .lsu_trans_id_i ( lsu_res_trans_id ),
        .alu_stall_o    ( alu_stall        ),
        .wb_valid_o     ( wb_valid_o       ),
        .wb_data_o      ( wb_data_o        ),
        .wb_trans_id_o  ( wb_trans_id_o    )
    );

endmodule

//--- test/tb_ex_stage.sv
`timescale 1ns/1ps

module tb_ex_stage;

    localparam int TID_BITS     = wb_pkg::TRANS_ID_BITS_DEFAULT;
    localparam int DMEM_WORDS   = 32;
    localparam int XLEN         = wb_pkg::XLEN;
    localparam int NUM_TAGS     = 1 << TID_BITS;
    localparam int FIELDS       = 7;
    localparam int MAX_PATTERNS = 64;
    localparam int RESET_CYCLES = 10;
    localparam int IDLE_CYCLES  = 4;
    localparam int DRAIN_CYCLES = 8;
    localparam int RAND_SEED    = 32'hb657;

    // Column order within one pattern line
    localparam int COL_UNIT = 0;
    localparam int COL_OP   = 1;
    localparam int COL_A    = 2;
    localparam int COL_B    = 3;
    localparam int COL_WD   = 4;
    localparam int COL_EXP  = 5;
    localparam int COL_NAME = 6;

    logic                clk = 1'b0;
    logic                rst_n;
    logic                alu_valid;
    op_pkg::op_word_t    alu_op;
    logic [XLEN-1:0]     alu_a;
    logic [XLEN-1:0]     alu_b;
    logic [TID_BITS-1:0] alu_tid;
    logic                alu_ready;
    logic                lsu_valid;
    op_pkg::op_word_t    lsu_op;
    logic [XLEN-1:0]     lsu_addr;
    logic [XLEN-1:0]     lsu_offset;
    logic [XLEN-1:0]     lsu_wdata;
    logic [TID_BITS-1:0] lsu_tid;
    logic                lsu_ready;
    logic                wb_valid;
    logic [XLEN-1:0]     wb_data;
    logic [TID_BITS-1:0] wb_tid;

    // ------------------------------
    // Pattern table and scoreboard
    // ------------------------------
    logic [XLEN-1:0] pat_mem [FIELDS*MAX_PATTERNS];
    bit              pending [NUM_TAGS];
    int              pend_pat [NUM_TAGS];
    int              wb_count [MAX_PATTERNS];
    int              num_patterns;
    int              next_pat;
    int              gap_left;
    int              cycle_cnt;
    int              cycle_limit;
    int              stall_cycles;
    int              value_errs;
    int              proto_errs;
    int              timeouts;
    bit              issued_any;

    always #5 clk = ~clk;

    ex_stage #(
        .TRANS_ID_BITS ( TID_BITS   ),
        .DMEM_WORDS    ( DMEM_WORDS )
    ) uut (
        .clk_i          ( clk        ),
        .rst_ni         ( rst_n      ),
        .alu_valid_i    ( alu_valid  ),
        .alu_op_i       ( alu_op     ),
        .alu_a_i        ( alu_a      ),
        .alu_b_i        ( alu_b      ),
        .alu_trans_id_i ( alu_tid    ),
        .alu_ready_o    ( alu_ready  ),
        .lsu_valid_i    ( lsu_valid  ),
        .lsu_op_i       ( lsu_op     ),
        .lsu_addr_i     ( lsu_addr   ),
        .lsu_offset_i   ( lsu_offset ),
        .lsu_wdata_i    ( lsu_wdata  ),
        .lsu_trans_id_i ( lsu_tid    ),
        .lsu_ready_o    ( lsu_ready  ),
        .wb_valid_o     ( wb_valid   ),
        .wb_data_o      ( wb_data    ),
        .wb_trans_id_o  ( wb_tid     )
    );

    function automatic string test_name(input int idx);
        case (idx)
            0:  return "add";
            1:  return "sub";
            2:  return "and";
            3:  return "or";
            4:  return "xor";
            5:  return "sll";
            6:  return "srl";
            7:  return "sra";
            8:  return "slt";
            9:  return "sltu";
            10: return "addw";
            11: return "subw";
            12: return "sllw";
            13: return "srlw";
            14: return "sraw";
            15: return "sd";
            16: return "sw";
            17: return "sh";
            18: return "sb";
            19: return "ld";
            20: return "lw";
            21: return "lwu";
            22: return "lh";
            23: return "lhu";
            24: return "lb";
            25: return "lbu";
            default: return "unknown";
        endcase
    endfunction

    function automatic logic [XLEN-1:0] field(input int pat, input int col);
        return pat_mem[pat*FIELDS + col];
    endfunction

    function automatic int outstanding();
        int n;
        n = 0;
        for (int t = 0; t < NUM_TAGS; t++) begin
            if (pending[t]) n++;
        end
        return n;
    endfunction

    // Outstanding operations that went to the ALU
    function automatic int alu_in_flight();
        int n;
        n = 0;
        for (int t = 0; t < NUM_TAGS; t++) begin
            if (pending[t] && field(pend_pat[t], COL_UNIT) == '0) n++;
        end
        return n;
    endfunction

    // Checks the DUT outputs of the current cycle on the falling edge
    task automatic check_writeback();
        int              pat;
        logic [XLEN-1:0] exp;
        assert (lsu_ready) else begin
            $display("lsu_ready_o went low in cycle %0d", cycle_cnt);
            proto_errs++;
        end
        // A held ALU result always shares the cycle with some writeback
        if (!alu_ready) begin
            stall_cycles++;
            assert (wb_valid) else begin
                $display("alu_ready_o low without a writeback in cycle %0d", cycle_cnt);
                proto_errs++;
            end
            assert (alu_in_flight() > 0) else begin
                $display("alu_ready_o low with no ALU result in flight in cycle %0d",
                         cycle_cnt);
                proto_errs++;
            end
        end
        if (!issued_any) begin
            assert (!wb_valid && alu_ready) else begin
                $display("Writeback or ALU stall seen before the first issue");
                proto_errs++;
            end
        end
        if (wb_valid) begin
            assert (pending[wb_tid]) else begin
                $display("Writeback with tag %0d that has no operation outstanding", wb_tid);
                proto_errs++;
            end
            if (pending[wb_tid]) begin
                pat = pend_pat[wb_tid];
                exp = field(pat, COL_EXP);
                wb_count[pat]++;
                pending[wb_tid] = 1'b0;
                assert (wb_data === exp) else begin
                    $display("ERR %s (pattern %0d, tag %0d): expected %h, actual %h",
                             test_name(int'(field(pat, COL_NAME))), pat, wb_tid, exp, wb_data);
                    value_errs++;
                end
            end
        end
    endtask

    // Drives at most one operation for the next rising edge
    task automatic issue_next();
        logic [XLEN-1:0]     unit_word;
        logic [7:0]          op_byte;
        logic [TID_BITS-1:0] tag;
        op_pkg::fu_t         unit;
        alu_valid = 1'b0;
        lsu_valid = 1'b0;
        if (next_pat >= num_patterns) return;
        if (gap_left > 0) begin
            gap_left--;
            return;
        end
        unit_word = field(next_pat, COL_UNIT);
        unit      = op_pkg::fu_t'(unit_word[0]);
        op_byte   = 8'(field(next_pat, COL_OP));
        tag       = TID_BITS'(next_pat % NUM_TAGS);
        // Tag still in flight from eight patterns back
        if (pending[tag]) return;
        if (unit == op_pkg::FU_ALU) begin
            if (!alu_ready) return;
            alu_valid = 1'b1;
            alu_op    = op_pkg::op_word_t'(op_byte);
            alu_a     = field(next_pat, COL_A);
            alu_b     = field(next_pat, COL_B);
            alu_tid   = tag;
        end else begin
            if (!lsu_ready) return;
            lsu_valid  = 1'b1;
            lsu_op     = op_pkg::op_word_t'(op_byte);
            lsu_addr   = field(next_pat, COL_A);
            lsu_offset = field(next_pat, COL_B);
            lsu_wdata  = field(next_pat, COL_WD);
            lsu_tid    = tag;
        end
        pending[tag]  = 1'b1;
        pend_pat[tag] = next_pat;
        issued_any    = 1'b1;
        next_pat++;
        gap_left = ($urandom % 4 == 0) ? int'($urandom % 3) + 1 : 0;
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        void'($urandom(RAND_SEED));
        rst_n      = 1'b0;
        alu_valid  = 1'b0;
        alu_op     = '0;
        alu_a      = '0;
        alu_b      = '0;
        alu_tid    = '0;
        lsu_valid  = 1'b0;
        lsu_op     = '0;
        lsu_addr   = '0;
        lsu_offset = '0;
        lsu_wdata  = '0;
        lsu_tid    = '0;
        next_pat     = 0;
        // Idle cycles before the first issue
        gap_left     = IDLE_CYCLES;
        cycle_cnt    = 0;
        stall_cycles = 0;
        value_errs   = 0;
        proto_errs   = 0;
        timeouts     = 0;
        issued_any   = 1'b0;
        for (int t = 0; t < NUM_TAGS; t++) begin
            pending[t]  = 1'b0;
            pend_pat[t] = 0;
        end
        for (int p = 0; p < MAX_PATTERNS; p++) wb_count[p] = 0;

        // All ones marks the end of the table
        for (int w = 0; w < FIELDS*MAX_PATTERNS; w++) pat_mem[w] = '1;
        $readmemh("test/ex_patterns.hex", pat_mem);
        num_patterns = 0;
        while (num_patterns < MAX_PATTERNS && pat_mem[num_patterns*FIELDS] !== '1) begin
            num_patterns++;
        end
        cycle_limit = 20*num_patterns + 200;

        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;

        while ((next_pat < num_patterns || outstanding() > 0) && cycle_cnt < cycle_limit) begin
            @(negedge clk);
            cycle_cnt++;
            check_writeback();
            issue_next();
        end
        if (next_pat < num_patterns || outstanding() > 0) begin
            $display("Timeout after %0d cycles, %0d patterns not issued, %0d results missing",
                     cycle_cnt, num_patterns - next_pat, outstanding());
            timeouts++;
        end

        // Any late writeback here is a duplicate
        repeat (DRAIN_CYCLES) begin
            @(negedge clk);
            alu_valid = 1'b0;
            lsu_valid = 1'b0;
            check_writeback();
        end

        assert (num_patterns > 0) else begin
            $display("No patterns were loaded from the pattern file");
            proto_errs++;
        end
        assert (stall_cycles > 0) else begin
            $display("alu_ready_o never dropped, so no merge collision was exercised");
            proto_errs++;
        end
        for (int p = 0; p < num_patterns; p++) begin
            assert (wb_count[p] == 1) else begin
                $display("Pattern %0d (%s) gave %0d writebacks instead of one",
                         p, test_name(int'(field(p, COL_NAME))), wb_count[p]);
                proto_errs++;
            end
        end

        $display("Errors: value %0d, protocol %0d, timeout %0d (%0d patterns, %0d stall cycles)",
                 value_errs, proto_errs, timeouts, num_patterns, stall_cycles);
        if (value_errs + proto_errs + timeouts == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- test/ex_patterns.hex
// unit op a_or_addr b_or_offset store_data expected name_idx
// unit 0 is the ALU and 1 the LSU, op is the 8-bit operation word
1 e0 0000000000000040 0000000000000008 8877665544332211 0000000000000000 0f
0 00 7fffffffffffffff 0000000000000001 0000000000000000 8000000000000000 00
1 e0 0000000000000058 fffffffffffffff8 0000000000000000 0000000000000000 0f
0 10 0000000000000003 0000000000000005 0000000000000000 fffffffffffffffe 01
1 c0 0000000000000054 0000000000000000 aaaaaaaacafef00d 0000000000000000 10
0 20 f0f0f0f0f0f0f0f0 ff00ff00ff00ff00 0000000000000000 f000f000f000f000 02
1 a0 0000000000000050 0000000000000002 ffffffffffffbeef 0000000000000000 11
0 30 f0f0f0f0f0f0f0f0 0f0f00000000ffff 0000000000000000 fffff0f0f0f0ffff 03
1 80 0000000000000050 0000000000000001 1234567812345680 0000000000000000 12
0 40 123456789abcdef0 ffffffffffffffff 0000000000000000 edcba9876543210f 04
1 60 0000000000000040 0000000000000008 0000000000000000 8877665544332211 13
0 50 00000000000000ff 0000000000000044 0000000000000000 0000000000000ff0 05
1 40 000000000000004c 0000000000000000 0000000000000000 ffffffff88776655 14
0 60 8000000000000000 000000000000003f 0000000000000000 0000000000000001 06
1 50 0000000000000048 0000000000000004 0000000000000000 0000000088776655 15
0 70 8000000000000000 0000000000000004 0000000000000000 f800000000000000 07
1 20 000000000000004e 0000000000000000 0000000000000000 ffffffffffff8877 16
0 80 ffffffffffffffff 0000000000000001 0000000000000000 0000000000000001 08
1 10 000000000000004f 0000000000000000 0000000000000000 0000000000000088 19
0 90 ffffffffffffffff 0000000000000001 0000000000000000 0000000000000000 09
1 00 000000000000004f 0000000000000000 0000000000000000 ffffffffffffff88 18
0 08 000000007fffffff 0000000000000001 0000000000000000 ffffffff80000000 0a
1 60 0000000000000050 0000000000000000 0000000000000000 cafef00dbeef8000 13
0 18 0000000100000000 0000000000000001 0000000000000000 ffffffffffffffff 0b
1 30 0000000000000052 0000000000000000 0000000000000000 000000000000beef 17
0 58 0000000000000001 000000000000003f 0000000000000000 ffffffff80000000 0c
1 00 0000000000000051 0000000000000000 0000000000000000 ffffffffffffff80 18
0 68 ffffffff80000000 0000000000000004 0000000000000000 0000000008000000 0d
1 60 0000000000000148 0000000000000000 0000000000000000 8877665544332211 13
0 78 0000000080000000 0000000000000004 0000000000000000 fffffffff8000000 0e

//--- tb.f
logic/op_pkg.sv
logic/wb_pkg.sv
logic/alu_unit.sv
logic/lsu_unit.sv
logic/result_merge.sv
logic/ex_stage.sv
test/tb_ex_stage.sv

//--- Makefile
# Verilator build for the execute stage testbench
# Run from the project root so the pattern file path resolves

VERILATOR ?= verilator
TOP       ?= tb_ex_stage
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --assert
PASS_MSG  ?= All checks passed

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -f $(FILELIST)

# Fails unless the pass message appears as a line of its own
run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
